// ==== dv/snb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_tb;

  import snb_pkg::*;

  localparam int CLK_PERIOD = 100;
  // Snoops per phase
  localparam int N_FILL = 24;
  localparam int N_MID  = 120;
  localparam int N_RAND = 300;
  localparam int TIMEOUT_CYCLES = 20 * (N_FILL + N_MID + N_RAND) + 200;
  // Model entry states
  localparam int M_IDLE  = 0;
  localparam int M_WAIT  = 1;
  localparam int M_READY = 2;

  logic                   ciu_clk;
  logic                   arst_n;
  logic                   snp_valid;
  logic                   snp_ready;
  logic [`SNB_ADDR_W-1:0] snp_addr;
  snb_op_e                snp_op;
  logic [`SNB_ID_W-1:0]   snp_id;
  logic                   resp_valid;
  logic [`SNB_ID_W-1:0]   resp_id;
  logic                   resp_dirty;
  logic                   out_valid;
  logic                   out_ready;
  logic [`SNB_ADDR_W-1:0] out_addr;
  snb_op_e                out_op;
  logic                   out_dirty;

  integer seed;

  // Reference model of the buffer
  int                     m_state [`SNB_DEPTH];
  logic [`SNB_ADDR_W-1:0] m_addr [`SNB_DEPTH];
  snb_op_e                m_op [`SNB_DEPTH];
  logic                   m_dirty [`SNB_DEPTH];
  // Live entries, oldest allocation at the front
  int                     m_order [$];
  logic                   m_ov;
  logic [`SNB_ADDR_W-1:0] m_oaddr;
  snb_op_e                m_oop;
  logic                   m_odirty;

  // Traffic knobs in percent
  int   p_snp;
  int   p_resp;
  int   p_ready;
  logic resp_en;
  int   snoops_left;
  logic snp_taken;
  int   n_acc;
  int   n_out;

  snb_top DUT (
    .ciu_clk    (ciu_clk),
    .arst_n     (arst_n),
    .snp_valid  (snp_valid),
    .snp_ready  (snp_ready),
    .snp_addr   (snp_addr),
    .snp_op     (snp_op),
    .snp_id     (snp_id),
    .resp_valid (resp_valid),
    .resp_id    (resp_id),
    .resp_dirty (resp_dirty),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_addr   (out_addr),
    .out_op     (out_op),
    .out_dirty  (out_dirty)
  );

  always #(CLK_PERIOD / 2) ciu_clk = ~ciu_clk;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      stop_on_error();
    end
  endtask

  function automatic int pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  // Lowest-index free entry, -1 when full
  function automatic int lowest_free();
    for (int i = 0; i < `SNB_DEPTH; i++) begin
      if (m_state[i] == M_IDLE) begin
        return i;
      end
    end
    return -1;
  endfunction

  // First answered entry in allocation order
  function automatic int oldest_ready();
    foreach (m_order[k]) begin
      if (m_state[m_order[k]] == M_READY) begin
        return m_order[k];
      end
    end
    return -1;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < `SNB_DEPTH; i++) begin
      m_state[i] = M_IDLE;
    end
    m_order.delete();
    m_ov      = 1'b0;
    snp_taken = 1'b0;
    n_acc     = 0;
    n_out     = 0;
  endtask

  // One clock edge of the model, using the inputs seen at that edge
  task automatic model_update();
    int   free_id;
    int   win;
    logic load;
    free_id   = lowest_free();
    win       = oldest_ready();
    load      = (win >= 0) && (!m_ov || out_ready);
    snp_taken = 1'b0;
    if (load) begin
      m_ov     = 1'b1;
      m_oaddr  = m_addr[win];
      m_oop    = m_op[win];
      // Make-invalid never reports dirty
      m_odirty = m_dirty[win] && (m_op[win] != SNP_MAKE_INVALID);
      m_state[win] = M_IDLE;
      foreach (m_order[k]) begin
        if (m_order[k] == win) begin
          m_order.delete(k);
          break;
        end
      end
    end else if (out_ready) begin
      m_ov = 1'b0;
    end
    if (resp_valid) begin
      m_state[resp_id] = M_READY;
      m_dirty[resp_id] = resp_dirty;
    end
    // Entry freed at this edge is not reusable until the next one
    if (snp_valid && free_id >= 0) begin
      m_state[free_id] = M_WAIT;
      m_addr[free_id]  = snp_addr;
      m_op[free_id]    = snp_op;
      m_order.push_back(free_id);
      snp_taken = 1'b1;
      n_acc++;
      snoops_left--;
    end
  endtask

  task automatic drive_inputs();
    int cands [$];
    int pick;
    // Source holds a pending snoop until it is taken
    if (!(snp_valid && !snp_taken)) begin
      if (snoops_left > 0 && pct() < p_snp) begin
        snp_valid <= 1'b1;
        snp_addr  <= $random(seed);
        snp_op    <= snb_op_e'($random(seed) & 3);
      end else begin
        snp_valid <= 1'b0;
      end
    end
    // Answer one outstanding entry at random
    for (int i = 0; i < `SNB_DEPTH; i++) begin
      if (m_state[i] == M_WAIT) begin
        cands.push_back(i);
      end
    end
    if (resp_en && cands.size() > 0 && pct() < p_resp) begin
      pick = cands[$unsigned($random(seed)) % cands.size()];
      resp_valid <= 1'b1;
      resp_id    <= `SNB_ID_W'(pick);
      resp_dirty <= $random(seed) & 1;
    end else begin
      resp_valid <= 1'b0;
    end
    out_ready <= (pct() < p_ready);
  endtask

  task automatic step();
    @(posedge ciu_clk);
    model_update();
    drive_inputs();
  endtask

  // Asynchronous reset in the middle of traffic
  task automatic apply_reset(input int cycles);
    @(posedge ciu_clk);
    arst_n     <= 1'b0;
    snp_valid  <= 1'b0;
    resp_valid <= 1'b0;
    out_ready  <= 1'b0;
    model_reset();
    repeat (cycles - 1) @(posedge ciu_clk);
    arst_n <= 1'b1;
    model_reset();
  endtask

  // Compare outputs away from the driving edge
  always @(negedge ciu_clk) begin
    check_value("snp_ready", lowest_free() >= 0, snp_ready);
    if (lowest_free() >= 0) begin
      check_value("snp_id", lowest_free(), snp_id);
    end
    check_value("out_valid", m_ov, out_valid);
    if (m_ov) begin
      check_value("out_addr", m_oaddr, out_addr);
      check_value("out_op", m_oop, out_op);
      check_value("out_dirty", m_odirty, out_dirty);
    end
    // Deliveries seen on the DUT output port
    if (out_valid && out_ready) begin
      n_out++;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("error: watchdog expired before all snoops were drained");
    stop_on_error();
  end

  initial begin
    seed       = 32'h98b82651;
    ciu_clk    = 1'b0;
    arst_n     = 1'b0;
    snp_valid  = 1'b0;
    snp_addr   = '0;
    snp_op     = SNP_READ_SHARED;
    resp_valid = 1'b0;
    resp_id    = '0;
    resp_dirty = 1'b0;
    out_ready  = 1'b0;
    model_reset();
    repeat (8) @(posedge ciu_clk);
    arst_n <= 1'b1;

    // Burst with no answers until the buffer is full
    snoops_left = N_FILL;
    p_snp   = 100;
    p_ready = 50;
    resp_en = 1'b0;
    while (lowest_free() >= 0) begin
      step();
    end
    // Stay full for a while with a snoop pending
    repeat (6) step();

    // Random answers under heavy back-pressure, then reset mid-traffic
    resp_en = 1'b1;
    p_snp   = 70;
    p_resp  = 50;
    p_ready = 35;
    snoops_left += N_MID;
    while (snoops_left > 0) begin
      step();
    end
    apply_reset(3);

    // Fresh traffic from empty
    snoops_left = N_RAND;
    p_snp   = 60;
    p_resp  = 40;
    p_ready = 70;
    while (snoops_left > 0) begin
      step();
    end

    // Drain everything still in flight
    p_resp  = 100;
    p_ready = 100;
    while (m_order.size() > 0 || m_ov || snp_valid) begin
      step();
    end
    repeat (3) step();

    assert (n_out == n_acc) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("error: %0d snoops accepted but %0d delivered", n_acc, n_out);
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

// ==== include/snb_defs.svh ====
`ifndef SNB_DEFS_SVH
`define SNB_DEFS_SVH

// Snoop buffer sizing

// Number of buffer entries
`define SNB_DEPTH 16

// Entry index width, log2 of the entry count
`define SNB_ID_W 4

// Snoop line address width
`define SNB_ADDR_W 32

`endif

// ==== src/snb_dp_sel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_dp_sel #(
  parameter int DEPTH = `SNB_DEPTH
) (
  input  logic [DEPTH-1:0] req_vld,
  input  logic [DEPTH-1:0] age_vect [DEPTH],
  output logic [DEPTH-1:0] sel
);

  // Requesters that some older requester blocks
  logic [DEPTH-1:0] blocked;

  // Entry wins when no older entry also requests
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      blocked[i] = |(req_vld & age_vect[i]);
      sel[i]     = req_vld[i] && !blocked[i];
    end
  end

  // No clock here, so checks are deferred to the end of the time step
  // Age rows must form a strict order over the live entries
  always_comb begin
    if (!$isunknown(req_vld)) begin
      a_sel_onehot: assert final ($onehot0(sel))
        else $error("snb_dp_sel: more than one winner %b", sel);
      // A request set without a winner means a cycle in the age rows
      a_sel_live: assert final (req_vld == '0 || sel != '0)
        else $error("snb_dp_sel: no winner for requests %b", req_vld);
    end
  end

endmodule

`default_nettype wire

// ==== src/snb_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_entry (
  input  logic                   ciu_clk,
  input  logic                   arst_n,
  input  logic                   alloc,
  input  logic [`SNB_ADDR_W-1:0] snp_addr,
  input  snb_pkg::snb_op_e       snp_op,
  input  logic                   resp_hit,
  input  logic                   resp_dirty,
  input  logic                   issue,
  output logic                   rdy,
  output logic [`SNB_ADDR_W-1:0] ent_addr,
  output snb_pkg::snb_op_e       ent_op,
  output logic                   ent_dirty
);

  import snb_pkg::*;

  snb_state_e state_q;
  snb_state_e state_d;

  // Lifecycle
  // Allocate, wait for the core, then wait for the output port
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ENT_IDLE: begin
        if (alloc) begin
          state_d = ENT_WAIT;
        end
      end
      ENT_WAIT: begin
        if (resp_hit) begin
          state_d = ENT_READY;
        end
      end
      ENT_READY: begin
        // Issue is the handoff into the output register
        if (issue) begin
          state_d = ENT_IDLE;
        end
      end
      default: begin
        state_d = ENT_IDLE;
      end
    endcase
  end

  always_ff @(posedge ciu_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ENT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, captured once per allocation
  always_ff @(posedge ciu_clk) begin
    if (alloc) begin
      ent_addr <= snp_addr;
      ent_op   <= snp_op;
    end
  end

  // Dirty flag from the core answer
  always_ff @(posedge ciu_clk) begin
    if (resp_hit) begin
      ent_dirty <= resp_dirty;
    end
  end

  // Request the output port only once answered
  assign rdy = (state_q == ENT_READY);

  // Core answers only outstanding snoops
  a_resp_in_wait: assert property (
    @(posedge ciu_clk) disable iff (!arst_n)
    resp_hit |-> state_q == ENT_WAIT
  );

endmodule

`default_nettype wire

// ==== src/snb_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_issue (
  input  logic                   ciu_clk,
  input  logic                   arst_n,
  input  logic [`SNB_DEPTH-1:0]  sel,
  input  logic [`SNB_ADDR_W-1:0] ent_addr [`SNB_DEPTH],
  input  snb_pkg::snb_op_e       ent_op [`SNB_DEPTH],
  input  logic [`SNB_DEPTH-1:0]  ent_dirty,
  input  logic                   out_ready,
  output logic [`SNB_DEPTH-1:0]  issue_vec,
  output logic                   out_valid,
  output logic [`SNB_ADDR_W-1:0] out_addr,
  output snb_pkg::snb_op_e       out_op,
  output logic                   out_dirty
);

  import snb_pkg::*;

  // Register can take a new entry this cycle
  logic                   load;
  // Selected entry's payload
  logic [`SNB_ADDR_W-1:0] mux_addr;
  snb_op_e                mux_op;
  logic                   mux_dirty;

  // Select is one-hot, so a plain scan acts as the mux
  always_comb begin
    mux_addr  = '0;
    mux_op    = SNP_READ_SHARED;
    mux_dirty = 1'b0;
    for (int i = 0; i < `SNB_DEPTH; i++) begin
      if (sel[i]) begin
        mux_addr  = ent_addr[i];
        mux_op    = ent_op[i];
        mux_dirty = ent_dirty[i];
      end
    end
  end

  // Empty or draining this cycle
  assign load = (|sel) && (!out_valid || out_ready);

  // Same-cycle release back to the winning entry
  assign issue_vec = load ? sel : '0;

  always_ff @(posedge ciu_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // One-deep payload stage
  always_ff @(posedge ciu_clk) begin
    if (load) begin
      out_addr  <= mux_addr;
      out_op    <= mux_op;
      // Make-invalid carries no data, so never report dirty
      out_dirty <= mux_dirty && (mux_op != SNP_MAKE_INVALID);
    end
  end

  // Held output under back-pressure
  a_out_stable: assert property (
    @(posedge ciu_clk) disable iff (!arst_n)
    out_valid && !out_ready |=>
      out_valid && $stable(out_addr) && $stable(out_op) && $stable(out_dirty)
  );

endmodule

`default_nettype wire

// ==== src/snb_order_track.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_order_track (
  input  logic                  ciu_clk,
  input  logic                  arst_n,
  input  logic                  snp_valid,
  input  logic [`SNB_DEPTH-1:0] issue_vec,
  output logic                  snp_ready,
  output logic [`SNB_ID_W-1:0]  snp_id,
  output logic [`SNB_DEPTH-1:0] alloc_vec,
  output logic [`SNB_DEPTH-1:0] age_vect [`SNB_DEPTH]
);

  // Occupied entries, one bit each
  logic [`SNB_DEPTH-1:0] occ_q;
  logic [`SNB_DEPTH-1:0] free_vec;
  // Occupancy once this cycle's issue has left
  logic [`SNB_DEPTH-1:0] occ_kept;
  // Diagonal of the age matrix, for checking only
  logic [`SNB_DEPTH-1:0] age_diag;

  assign free_vec  = ~occ_q;
  assign occ_kept  = occ_q & ~issue_vec;
  // Ready follows registered occupancy only
  // An entry issuing this cycle is not reused until the next one
  assign snp_ready = |free_vec;

  // Lowest free index wins
  // Scan from the top so the last hit is the smallest index
  always_comb begin
    snp_id = '0;
    for (int i = `SNB_DEPTH - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        snp_id = `SNB_ID_W'(i);
      end
    end
  end

  // One-hot allocate strobe to the entries
  always_comb begin
    alloc_vec = '0;
    if (snp_valid && snp_ready) begin
      alloc_vec[snp_id] = 1'b1;
    end
  end

  // Occupancy mask
  always_ff @(posedge ciu_clk or negedge arst_n) begin
    if (!arst_n) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_kept | alloc_vec;
    end
  end

  // Age matrix
  // Row i lists entries allocated before entry i that are still live
  always_ff @(posedge ciu_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `SNB_DEPTH; i++) begin
        age_vect[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `SNB_DEPTH; i++) begin
        if (alloc_vec[i]) begin
          // Everyone already here is older, minus entries leaving now
          age_vect[i] <= occ_kept;
        end else begin
          // Freed entries drop out of every row
          age_vect[i] <= age_vect[i] & ~issue_vec;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `SNB_DEPTH; i++) begin
      age_diag[i] = age_vect[i][i];
    end
  end

  // Allocation must land on a free slot
  a_alloc_free: assert property (
    @(posedge ciu_clk) disable iff (!arst_n)
    (alloc_vec & occ_q) == '0
  );

  // No entry can be older than itself
  a_age_diag: assert property (
    @(posedge ciu_clk) disable iff (!arst_n)
    age_diag == '0
  );

  // Issued entries must have been occupied
  a_issue_occ: assert property (
    @(posedge ciu_clk) disable iff (!arst_n)
    (issue_vec & ~occ_q) == '0
  );

endmodule

`default_nettype wire

// ==== src/snb_pkg.sv ====
`default_nettype none

package snb_pkg;

  // Snoop opcodes as seen on the request port
  typedef enum logic [1:0] {
    SNP_READ_SHARED   = 2'b00,
    SNP_READ_UNIQUE   = 2'b01,
    SNP_CLEAN_INVALID = 2'b10,
    // Invalidate only, never returns data
    SNP_MAKE_INVALID  = 2'b11
  } snb_op_e;

  // Per-entry lifecycle
  typedef enum logic [1:0] {
    // Free slot
    ENT_IDLE  = 2'b00,
    // Allocated, core answer outstanding
    ENT_WAIT  = 2'b01,
    // Answered, competing for the output port
    ENT_READY = 2'b10
  } snb_state_e;

endpackage

`default_nettype wire

// ==== src/snb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snb_defs.svh"

module snb_top (
  input  logic                   ciu_clk,
  input  logic                   arst_n,
  // Snoop request
  input  logic                   snp_valid,
  output logic                   snp_ready,
  input  logic [`SNB_ADDR_W-1:0] snp_addr,
  input  snb_pkg::snb_op_e       snp_op,
  output logic [`SNB_ID_W-1:0]   snp_id,
  // Core answer, no back-pressure
  input  logic                   resp_valid,
  input  logic [`SNB_ID_W-1:0]   resp_id,
  input  logic                   resp_dirty,
  // To the snoop datapath
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`SNB_ADDR_W-1:0] out_addr,
  output snb_pkg::snb_op_e       out_op,
  output logic                   out_dirty
);

  import snb_pkg::*;

  logic [`SNB_DEPTH-1:0]  alloc_vec;
  logic [`SNB_DEPTH-1:0]  issue_vec;
  logic [`SNB_DEPTH-1:0]  rdy_vec;
  logic [`SNB_DEPTH-1:0]  sel;
  logic [`SNB_DEPTH-1:0]  resp_hit;
  logic [`SNB_DEPTH-1:0]  age_vect [`SNB_DEPTH];
  // Per-entry payload toward the output mux
  logic [`SNB_ADDR_W-1:0] ent_addr [`SNB_DEPTH];
  snb_op_e                ent_op [`SNB_DEPTH];
  logic [`SNB_DEPTH-1:0]  ent_dirty;

  // Allocation and relative age
  snb_order_track u_order_track (
    .ciu_clk   (ciu_clk),
    .arst_n    (arst_n),
    .snp_valid (snp_valid),
    .issue_vec (issue_vec),
    .snp_ready (snp_ready),
    .snp_id    (snp_id),
    .alloc_vec (alloc_vec),
    .age_vect  (age_vect)
  );

  for (genvar i = 0; i < `SNB_DEPTH; i++) begin : g_entry
    // Decode the answer to its entry
    assign resp_hit[i] = resp_valid && (resp_id == `SNB_ID_W'(i));

    snb_entry u_entry (
      .ciu_clk    (ciu_clk),
      .arst_n     (arst_n),
      .alloc      (alloc_vec[i]),
      .snp_addr   (snp_addr),
      .snp_op     (snp_op),
      .resp_hit   (resp_hit[i]),
      .resp_dirty (resp_dirty),
      .issue      (issue_vec[i]),
      .rdy        (rdy_vec[i]),
      .ent_addr   (ent_addr[i]),
      .ent_op     (ent_op[i]),
      .ent_dirty  (ent_dirty[i])
    );
  end

  // Oldest answered entry
  snb_dp_sel #(
    .DEPTH (`SNB_DEPTH)
  ) u_dp_sel (
    .req_vld  (rdy_vec),
    .age_vect (age_vect),
    .sel      (sel)
  );

  // Output register
  snb_issue u_issue (
    .ciu_clk   (ciu_clk),
    .arst_n    (arst_n),
    .sel       (sel),
    .ent_addr  (ent_addr),
    .ent_op    (ent_op),
    .ent_dirty (ent_dirty),
    .out_ready (out_ready),
    .issue_vec (issue_vec),
    .out_valid (out_valid),
    .out_addr  (out_addr),
    .out_op    (out_op),
    .out_dirty (out_dirty)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
src/snb_pkg.sv
src/snb_order_track.sv
src/snb_dp_sel.sv
src/snb_entry.sv
src/snb_issue.sv
src/snb_top.sv
dv/snb_tb.sv
